// ==== rtl/download_pkg.sv ====
// Host download protocol definitions, imported by every RTL module and the testbench
package download_pkg;

	//////////////////////////////////////////////////
	// Host port widths
	//////////////////////////////////////////////////

	localparam int HOST_DATA_W = 16;
	localparam int HOST_ADDR_W = 25;
	localparam int INDEX_W     = 8;
	localparam int BYTE_W      = 8;
	localparam int CD_LEN_W    = 15;

	// Index classification looks at the low six bits only
	localparam int INDEX_SEL_W = 6;

	localparam logic [INDEX_SEL_W-1:0] INDEX_CART_MAX = 6'd1;
	localparam logic [INDEX_SEL_W-1:0] INDEX_CD_DATA  = 6'd2;
	localparam logic [INDEX_SEL_W-1:0] INDEX_CD_AUDIO = 6'd3;

	// Download kinds; a cheat file is index 0xFF
	typedef enum logic [1:0] {
		KIND_CART     = 2'd0,
		KIND_CD_DATA  = 2'd1,
		KIND_CD_AUDIO = 2'd2,
		KIND_CHEAT    = 2'd3
	} kind_t;

	//////////////////////////////////////////////////
	// CD stream word, header or two data bytes
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                mode;
		logic [CD_LEN_W-1:0] length;
	} cd_header_t;

	typedef struct packed {
		logic [BYTE_W-1:0] byte_hi;
		logic [BYTE_W-1:0] byte_lo;
	} cd_data_t;

	typedef union packed {
		cd_header_t header;
		cd_data_t   data;
	} stream_word_u;

endpackage

// ==== rtl/cheat_pkg.sv ====
// Cheat code layout and cheat file word map, imported by the assembler, top level and testbench
package cheat_pkg;

	localparam int CHEAT_FIELD_W = 32;
	localparam int CHEAT_CODE_W  = 4 * CHEAT_FIELD_W;
	localparam int CHEAT_HALF_W  = CHEAT_FIELD_W / 2;
	localparam int CHEAT_OFS_W   = 4;

	// Field positions, flags on top and replace at the bottom
	localparam int REPLACE_LSB = 0;
	localparam int COMPARE_LSB = CHEAT_FIELD_W;
	localparam int ADDRESS_LSB = 2 * CHEAT_FIELD_W;
	localparam int FLAGS_LSB   = 3 * CHEAT_FIELD_W;

	// Byte offsets of each half word within one code
	localparam logic [CHEAT_OFS_W-1:0] OFS_FLAGS_LO   = 4'd0;
	localparam logic [CHEAT_OFS_W-1:0] OFS_FLAGS_HI   = 4'd2;
	localparam logic [CHEAT_OFS_W-1:0] OFS_ADDRESS_LO = 4'd4;
	localparam logic [CHEAT_OFS_W-1:0] OFS_ADDRESS_HI = 4'd6;
	localparam logic [CHEAT_OFS_W-1:0] OFS_COMPARE_LO = 4'd8;
	localparam logic [CHEAT_OFS_W-1:0] OFS_COMPARE_HI = 4'd10;
	localparam logic [CHEAT_OFS_W-1:0] OFS_REPLACE_LO = 4'd12;
	localparam logic [CHEAT_OFS_W-1:0] OFS_REPLACE_HI = 4'd14;

	// Writing this word completes a code
	localparam logic [CHEAT_OFS_W-1:0] CHEAT_LAST_OFFSET = OFS_REPLACE_HI;

endpackage

// ==== rtl/download_stream_if.sv ====
// Classified and registered host stream, driven by the decoder and read by the cheat and CD blocks
interface download_stream_if
	import download_pkg::*;
();

	kind_t                  kind;
	// Download running with a known index
	logic                   active;
	// First active cycle only
	logic                   start;
	logic                   wr;
	logic [HOST_ADDR_W-1:0] addr;
	logic [HOST_DATA_W-1:0] data;

	modport source (
		output kind, active, start, wr, addr, data
	);

	modport sink (
		input kind, active, start, wr, addr, data
	);

endinterface

// ==== rtl/cd_word_if.sv ====
// Parsed CD stream words, passed from the header unpacker to the byte serializer
interface cd_word_if
	import download_pkg::*;
();

	// New CD download, count must restart
	logic                restart;
	logic [CD_LEN_W-1:0] length;
	logic                mode;
	logic                audio;
	logic                word_valid;
	stream_word_u        word;

	modport source (
		output restart, length, mode, audio, word_valid, word
	);

	modport sink (
		input restart, length, mode, audio, word_valid, word
	);

endinterface

// ==== rtl/download_decode.sv ====
// Front stage of the router: classifies the file index and registers the host download port
module download_decode
	import download_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   download,
	input  logic                   wr,
	input  logic [INDEX_W-1:0]     index,
	input  logic [HOST_ADDR_W-1:0] addr,
	input  logic [HOST_DATA_W-1:0] data,
	download_stream_if.source      stream
);

	kind_t kind_next;
	logic  known;
	logic  live;

	//////////////////////////////////////////////////
	// Index rule
	//////////////////////////////////////////////////

	always_comb begin
		known = 1'b1;
		kind_next = KIND_CART;
		if (&index) begin
			kind_next = KIND_CHEAT;
		end else if (index[INDEX_SEL_W-1:0] <= INDEX_CART_MAX) begin
			kind_next = KIND_CART;
		end else if (index[INDEX_SEL_W-1:0] == INDEX_CD_DATA) begin
			kind_next = KIND_CD_DATA;
		end else if (index[INDEX_SEL_W-1:0] == INDEX_CD_AUDIO) begin
			kind_next = KIND_CD_AUDIO;
		end else begin
			known = 1'b0;
		end
	end

	// Unknown indices never become active
	assign live = download & known;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stream.active <= 1'b0;
			stream.start <= 1'b0;
			stream.wr <= 1'b0;
			stream.kind <= KIND_CART;
		end else begin
			stream.active <= live;
			// Rising edge of a classified download
			stream.start <= live & ~stream.active;
			stream.wr <= wr & live;
			stream.kind <= kind_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		stream.addr <= addr;
		stream.data <= data;
	end

endmodule

// ==== rtl/cheat_code_assembler.sv ====
// Builds 128-bit cheat codes from cheat file words and pulses code-ready and cheat-clear
module cheat_code_assembler
	import download_pkg::*;
	import cheat_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	download_stream_if.sink         stream,
	output logic [CHEAT_CODE_W-1:0] cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_clear
);

	logic                   cheat_wr;
	logic                   clear_wr;
	logic [CHEAT_OFS_W-1:0] ofs;

	assign cheat_wr = stream.wr & stream.active & (stream.kind == KIND_CHEAT);
	assign ofs = stream.addr[CHEAT_OFS_W-1:0];

	// Cart and cheat files both wipe the code table when they begin
	assign clear_wr = stream.wr & stream.active
		& ((stream.kind == KIND_CART) | (stream.kind == KIND_CHEAT))
		& (stream.addr == '0);

	//////////////////////////////////////////////////
	// Word placement
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (ofs)
				OFS_FLAGS_LO:   cheat_code[FLAGS_LSB +: CHEAT_HALF_W] <= stream.data;
				OFS_FLAGS_HI:   cheat_code[FLAGS_LSB + CHEAT_HALF_W +: CHEAT_HALF_W] <= stream.data;
				OFS_ADDRESS_LO: cheat_code[ADDRESS_LSB +: CHEAT_HALF_W] <= stream.data;
				OFS_ADDRESS_HI: cheat_code[ADDRESS_LSB + CHEAT_HALF_W +: CHEAT_HALF_W] <= stream.data;
				OFS_COMPARE_LO: cheat_code[COMPARE_LSB +: CHEAT_HALF_W] <= stream.data;
				OFS_COMPARE_HI: cheat_code[COMPARE_LSB + CHEAT_HALF_W +: CHEAT_HALF_W] <= stream.data;
				OFS_REPLACE_LO: cheat_code[REPLACE_LSB +: CHEAT_HALF_W] <= stream.data;
				OFS_REPLACE_HI: cheat_code[REPLACE_LSB + CHEAT_HALF_W +: CHEAT_HALF_W] <= stream.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last half word lands together with this pulse
			cheat_valid <= cheat_wr & (ofs == CHEAT_LAST_OFFSET);
			cheat_clear <= clear_wr;
		end
	end

endmodule

// ==== rtl/cd_header_unpack.sv ====
// Splits a CD download into its header (mode, length) and the data words that follow it
module cd_header_unpack
	import download_pkg::*;
(
	input  logic            clk_sys,
	input  logic            reset,
	download_stream_if.sink stream,
	cd_word_if.source       words
);

	stream_word_u host_word;
	logic         cd_active;
	logic         cd_wr;
	logic         header_seen;
	logic         header_due;

	assign host_word = stream.data;
	assign cd_active = stream.active
		& ((stream.kind == KIND_CD_DATA) | (stream.kind == KIND_CD_AUDIO));
	assign cd_wr = stream.wr & cd_active;

	// A write in the start cycle is always the header
	assign header_due = stream.start | ~header_seen;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			header_seen <= 1'b0;
			words.restart <= 1'b0;
			words.word_valid <= 1'b0;
			words.length <= '0;
			words.mode <= 1'b0;
			words.audio <= 1'b0;
		end else begin
			words.restart <= stream.start & cd_active;
			words.word_valid <= cd_wr & ~header_due;

			if (stream.start) begin
				header_seen <= 1'b0;
				words.length <= '0;
				words.audio <= (stream.kind == KIND_CD_AUDIO);
			end

			// Header view of the first word
			if (cd_wr && header_due) begin
				header_seen <= 1'b1;
				words.mode <= host_word.header.mode;
				words.length <= host_word.header.length;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cd_wr && !header_due) begin
			words.word <= host_word;
		end
	end

endmodule

// ==== rtl/cd_byte_serializer.sv ====
// Turns CD data words into low/high byte strobes on the data or audio write line, up to the length
module cd_byte_serializer
	import download_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	cd_word_if.sink           words,
	output logic [BYTE_W-1:0] cd_byte,
	output logic              cd_data_wr,
	output logic              cd_audio_wr,
	output logic              cd_mode
);

	// Idle cycle between the two bytes of a word
	localparam logic [1:0] PH_IDLE = 2'd0;
	localparam logic [1:0] PH_GAP  = 2'd1;
	localparam logic [1:0] PH_HIGH = 2'd2;

	logic [1:0]          phase;
	logic [CD_LEN_W-1:0] count;
	logic                room;

	// Bytes left before the header length is used up
	assign room = count < words.length;
	assign cd_mode = words.mode;

	//////////////////////////////////////////////////
	// Byte sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= PH_IDLE;
			count <= '0;
			cd_data_wr <= 1'b0;
			cd_audio_wr <= 1'b0;
		end else begin
			cd_data_wr <= 1'b0;
			cd_audio_wr <= 1'b0;

			if (words.restart) begin
				phase <= PH_IDLE;
				count <= '0;
			end else if (words.word_valid) begin
				phase <= PH_GAP;
				if (room) begin
					cd_data_wr <= ~words.audio;
					cd_audio_wr <= words.audio;
					count <= count + CD_LEN_W'(1);
				end
			end else if (phase == PH_GAP) begin
				phase <= PH_HIGH;
			end else if (phase == PH_HIGH) begin
				phase <= PH_IDLE;
				// Odd lengths drop the last high byte here
				if (room) begin
					cd_data_wr <= ~words.audio;
					cd_audio_wr <= words.audio;
					count <= count + CD_LEN_W'(1);
				end
			end
		end
	end

	// Word stays stable in the unpacker until the next word_valid
	always_ff @(posedge clk_sys) begin
		if (words.word_valid) begin
			cd_byte <= words.word.data.byte_lo;
		end else if (phase == PH_HIGH) begin
			cd_byte <= words.word.data.byte_hi;
		end
	end

endmodule

// ==== rtl/download_router_top.sv ====
// Download router top level; connect the host file-download port and take cheat and CD outputs
module download_router_top
	import download_pkg::*;
	import cheat_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,

	// Host file-download port
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [INDEX_W-1:0]      ioctl_index,
	input  logic [HOST_ADDR_W-1:0]  ioctl_addr,
	input  logic [HOST_DATA_W-1:0]  ioctl_dout,

	// Cheat engine side
	output logic [CHEAT_CODE_W-1:0] cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_clear,

	// CD byte stream
	output logic [BYTE_W-1:0]       cd_byte,
	output logic                    cd_data_wr,
	output logic                    cd_audio_wr,
	output logic                    cd_mode
);

	download_stream_if stream_if ();
	cd_word_if cd_if ();

	//////////////////////////////////////////////////
	// Classification
	//////////////////////////////////////////////////

	download_decode decode_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.download (ioctl_download),
		.wr       (ioctl_wr),
		.index    (ioctl_index),
		.addr     (ioctl_addr),
		.data     (ioctl_dout),
		.stream   (stream_if.source)
	);

	//////////////////////////////////////////////////
	// Consumers
	//////////////////////////////////////////////////

	cheat_code_assembler cheat_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stream      (stream_if.sink),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	cd_header_unpack unpack_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.stream  (stream_if.sink),
		.words   (cd_if.source)
	);

	cd_byte_serializer serializer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.words       (cd_if.sink),
		.cd_byte     (cd_byte),
		.cd_data_wr  (cd_data_wr),
		.cd_audio_wr (cd_audio_wr),
		.cd_mode     (cd_mode)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock (period 10) and synchronous reset held for the first 10 cycles
module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Released on a falling edge, away from the DUT sampling edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

// ==== verification/download_router_assertions.sv ====
// Strobe rules for the CD byte serializer, bound into every serializer instance
module download_router_assertions (
	input logic clk_sys,
	input logic reset,
	input logic cd_data_wr,
	input logic cd_audio_wr
);

	int   failures = 0;
	logic strobe;

	assign strobe = cd_data_wr | cd_audio_wr;

	// Data and audio share cd_byte
	strobe_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(cd_data_wr && cd_audio_wr))
	else begin
		failures++;
		$error("CD data and audio strobes are high in the same cycle");
	end

	// Every byte strobe is followed by an idle cycle
	strobe_gap: assert property (@(posedge clk_sys) disable iff (reset)
		strobe |=> !strobe)
	else begin
		failures++;
		$error("CD byte strobes in two consecutive cycles");
	end

	reset_quiet: assert property (@(posedge clk_sys) reset |=> !strobe)
	else begin
		failures++;
		$error("CD byte strobe while reset is asserted");
	end

endmodule

bind cd_byte_serializer download_router_assertions assertions_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.cd_data_wr  (cd_data_wr),
	.cd_audio_wr (cd_audio_wr)
);

// ==== verification/download_router_tb.sv ====
// Directed testbench for the download router; run with download_router_tb as top module
module download_router_tb
	import download_pkg::*;
	import cheat_pkg::*;
;

	localparam int CLK_PERIOD    = 10;
	localparam int WAIT_LIMIT    = 100;
	localparam int SETTLE_CYCLES = 10;
	// Minimum host spacing of CD words
	localparam int WORD_GAP      = 6;

	logic                    clk_sys;
	logic                    reset;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [INDEX_W-1:0]      ioctl_index;
	logic [HOST_ADDR_W-1:0]  ioctl_addr;
	logic [HOST_DATA_W-1:0]  ioctl_dout;
	logic [CHEAT_CODE_W-1:0] cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;
	logic [BYTE_W-1:0]       cd_byte;
	logic                    cd_data_wr;
	logic                    cd_audio_wr;
	logic                    cd_mode;

	// Observed events, sampled on the falling edge
	logic [BYTE_W-1:0] byte_q[$];
	kind_t             kind_q[$];
	time               strobe_time_q[$];
	time               valid_time_q[$];
	int                clear_count;

	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;
	logic [31:0] rng_state = 32'd51982;

	tb_clock_gen clock_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	download_router_top dut_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid),
		.cheat_clear    (cheat_clear),
		.cd_byte        (cd_byte),
		.cd_data_wr     (cd_data_wr),
		.cd_audio_wr    (cd_audio_wr),
		.cd_mode        (cd_mode)
	);

	always @(negedge clk_sys) begin
		if (!reset) begin
			if (cd_data_wr) begin
				byte_q.push_back(cd_byte);
				kind_q.push_back(KIND_CD_DATA);
				strobe_time_q.push_back($time);
			end
			if (cd_audio_wr) begin
				byte_q.push_back(cd_byte);
				kind_q.push_back(KIND_CD_AUDIO);
				strobe_time_q.push_back($time);
			end
			if (cheat_valid) begin
				valid_time_q.push_back($time);
			end
			if (cheat_clear) begin
				clear_count++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Random words and compare tasks
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [HOST_DATA_W-1:0] random_word();
		rng_state = xorshift32(rng_state);
		return rng_state[HOST_DATA_W-1:0];
	endfunction

	task automatic compare_cheat_code(input string what, input logic [CHEAT_CODE_W-1:0] got,
		input logic [CHEAT_CODE_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_cd_byte(input string what, input logic [BYTE_W-1:0] got,
		input kind_t got_kind, input logic [BYTE_W-1:0] exp, input kind_t exp_kind);
		checks++;
		if (got !== exp || got_kind != exp_kind) begin
			errors++;
			$display("[ERROR] %0t: %s is %h on %s, expected %h on %s", $time, what,
				got, got_kind.name(), exp, exp_kind.name());
		end
	endtask

	task automatic compare_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Host port driving and waits
	//////////////////////////////////////////////////

	task automatic clear_records();
		byte_q.delete();
		kind_q.delete();
		strobe_time_q.delete();
		valid_time_q.delete();
		clear_count = 0;
	endtask

	task automatic start_download(input logic [INDEX_W-1:0] index);
		ioctl_index = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// One-cycle write strobe; returns the time it was driven
	task automatic host_write(input logic [HOST_ADDR_W-1:0] addr,
		input logic [HOST_DATA_W-1:0] data, output time t_wr);
		t_wr = $time;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic wait_strobes(input int n);
		int cycles;
		cycles = 0;
		while (byte_q.size() < n && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (byte_q.size() < n) begin
			timeouts++;
			$display("Timed out waiting for %0d CD byte strobes, only %0d came", n, byte_q.size());
		end
	endtask

	task automatic wait_cheat_pulse(input bit want_clear);
		int cycles;
		cycles = 0;
		while ((want_clear ? clear_count : valid_time_q.size()) == 0 && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if ((want_clear ? clear_count : valid_time_q.size()) == 0) begin
			timeouts++;
			$display("Timed out waiting for a %s pulse", want_clear ? "cheat_clear" : "cheat_valid");
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic idle_after_reset();
		clear_records();
		repeat (20) @(negedge clk_sys);
		compare_count("Strobes before any download",
			byte_q.size() + valid_time_q.size() + clear_count, 0);
	endtask

	task automatic cheat_code_download();
		logic [HOST_DATA_W-1:0]  w[8];
		logic [CHEAT_CODE_W-1:0] exp_code;
		time                     t_last;
		int                      i;
		clear_records();
		start_download(8'hFF);
		for (i = 0; i < 8; i++) begin
			w[i] = random_word();
			host_write(HOST_ADDR_W'(2 * i), w[i], t_last);
		end
		wait_cheat_pulse(1'b0);
		repeat (SETTLE_CYCLES) @(negedge clk_sys);
		end_download();
		// Flags, address, compare, replace; high half at the higher offset
		exp_code = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		compare_count("cheat_valid pulses", valid_time_q.size(), 1);
		if (valid_time_q.size() > 0) begin
			compare_count("cheat_valid delay in cycles",
				int'((valid_time_q[0] - t_last) / CLK_PERIOD), 2);
		end
		compare_cheat_code("cheat_code", cheat_code, exp_code);
	endtask

	task automatic clear_for_index(input logic [INDEX_W-1:0] index, input int exp);
		time t_wr;
		clear_records();
		start_download(index);
		host_write('0, '0, t_wr);
		if (exp > 0) begin
			wait_cheat_pulse(1'b1);
		end
		repeat (SETTLE_CYCLES) @(negedge clk_sys);
		end_download();
		compare_count($sformatf("cheat_clear pulses for index %h", index), clear_count, exp);
	endtask

	task automatic cheat_clear_rules();
		clear_for_index(8'h00, 1);
		clear_for_index(8'h01, 1);
		clear_for_index(8'hFF, 1);
		clear_for_index(8'h02, 0);
	endtask

	// Header, then data words; bytes go out low first until the length is used up
	task automatic run_cd_download(input logic [INDEX_W-1:0] index, input logic mode,
		input int length, input int n_words, input kind_t exp_kind, output time first_wr);
		logic [HOST_DATA_W-1:0] word;
		logic [BYTE_W-1:0]      exp_bytes[$];
		time                    t_wr;
		int                     n_exp;
		int                     i;
		clear_records();
		start_download(index);
		host_write('0, {mode, CD_LEN_W'(length)}, t_wr);
		repeat (WORD_GAP - 1) @(negedge clk_sys);
		for (i = 0; i < n_words; i++) begin
			word = random_word();
			exp_bytes.push_back(word[7:0]);
			exp_bytes.push_back(word[15:8]);
			host_write(HOST_ADDR_W'(2 * (i + 1)), word, t_wr);
			if (i == 0) begin
				first_wr = t_wr;
			end
			repeat (WORD_GAP - 1) @(negedge clk_sys);
		end
		n_exp = (length < exp_bytes.size()) ? length : exp_bytes.size();
		wait_strobes(n_exp);
		repeat (SETTLE_CYCLES) @(negedge clk_sys);
		end_download();
		compare_count("CD byte strobes", byte_q.size(), n_exp);
		for (i = 0; i < n_exp && i < byte_q.size(); i++) begin
			compare_cd_byte($sformatf("CD byte %0d", i), byte_q[i], kind_q[i],
				exp_bytes[i], exp_kind);
		end
		compare_flag("cd_mode", cd_mode, mode);
	endtask

	task automatic cd_data_stream();
		time t_first;
		run_cd_download(8'h02, 1'b1, 5, 3, KIND_CD_DATA, t_first);
	endtask

	task automatic cd_audio_stream();
		time t_first;
		run_cd_download(8'h03, 1'b0, 4, 2, KIND_CD_AUDIO, t_first);
		if (strobe_time_q.size() > 0) begin
			compare_count("First audio strobe delay in cycles",
				int'((strobe_time_q[0] - t_first) / CLK_PERIOD), 3);
		end
	endtask

	// Second header must reset the byte count
	task automatic cd_stream_restart();
		time t_first;
		run_cd_download(8'h02, 1'b0, 2, 1, KIND_CD_DATA, t_first);
		run_cd_download(8'h02, 1'b1, 6, 3, KIND_CD_DATA, t_first);
	endtask

	initial begin
		int cycles;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		clear_count = 0;
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
		end while (reset && cycles < WAIT_LIMIT);
		if (reset) begin
			timeouts++;
			$display("Reset was never released");
		end

		idle_after_reset();
		cheat_code_download();
		cheat_clear_rules();
		cd_data_stream();
		cd_audio_stream();
		cd_stream_restart();

		$display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
			checks, errors, timeouts, dut_i.serializer_i.assertions_i.failures);
		if (errors == 0 && timeouts == 0 && dut_i.serializer_i.assertions_i.failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
rtl/download_pkg.sv
rtl/cheat_pkg.sv
rtl/download_stream_if.sv
rtl/cd_word_if.sv
rtl/download_decode.sv
rtl/cheat_code_assembler.sv
rtl/cd_header_unpack.sv
rtl/cd_byte_serializer.sv
rtl/download_router_top.sv
verification/tb_clock_gen.sv
verification/download_router_assertions.sv
verification/download_router_tb.sv

// ==== Bender.yml ====
package:
  name: download_router

sources:
  - files:
      - rtl/download_pkg.sv
      - rtl/cheat_pkg.sv
      - rtl/download_stream_if.sv
      - rtl/cd_word_if.sv
      - rtl/download_decode.sv
      - rtl/cheat_code_assembler.sv
      - rtl/cd_header_unpack.sv
      - rtl/cd_byte_serializer.sv
      - rtl/download_router_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/download_router_assertions.sv
      - verification/download_router_tb.sv
